/* hdl/recovery_cmd_fsm.sv */
// Command sequencer: validates decoded commands, moves TTI words to CSRs or FIFO, streams reads
`timescale 1ns/100ps
`default_nettype none
`include "recovery_settings.svh"

module recovery_cmd_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cmd_valid_i,
  input  logic                        cmd_is_rd_i,
  input  logic [7:0]                  cmd_cmd_i,
  input  logic [`RECOVERY_LEN_W-1:0]  cmd_len_i,
  input  logic                        cmd_error_i,
  output logic                        cmd_done_o,
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output logic [`RECOVERY_LEN_W-1:0]  res_len_o,
  output logic                        res_dvalid_o,
  input  logic                        res_dready_i,
  output logic [7:0]                  res_data_o,
  output logic                        res_dlast_o,
  output logic                        tti_rx_rreq_o,
  input  logic                        tti_rx_rack_i,
  input  logic [`RECOVERY_DATA_W-1:0] tti_rx_rdata_i,
  output logic                        rx_queue_clr_o,
  input  logic                        host_abort_i,
  input  logic                        recovery_mode_enabled_i,
  csr_access_if.sequencer             csr,
  fifo_link_if.writer                 fifo
);

  typedef enum logic [2:0] {
    Idle, CsrWrite, FifoWrite, CsrRead, CsrReadLen, CsrReadData, Error, Done
  } state_e;

  state_e                          state_q, state_d;
  logic [`RECOVERY_LEN_W-1:0]      cnt_q;
  logic [`RECOVERY_LEN_W-1:0]      words;
  logic [1:0]                      bcnt_q;
  logic [7:0]                      cmd_q;
  logic                            crc_q;
  logic                            rreq_q;
  logic                            res_valid_q;
  recovery_cmd_pkg::cmd_len_t      len_q;
  recovery_csr_pkg::csr_word_e     sel_q;
  logic                            in_range, mode_ok, dropped, cmd_ok;

  // First register word addressed by a command
  function automatic recovery_csr_pkg::csr_word_e first_word(logic [7:0] cmd);
    case (cmd)
      recovery_cmd_pkg::CMD_DEVICE_STATUS:        return recovery_csr_pkg::CSR_DEVICE_STATUS_0;
      recovery_cmd_pkg::CMD_DEVICE_RESET:         return recovery_csr_pkg::CSR_DEVICE_RESET;
      recovery_cmd_pkg::CMD_RECOVERY_CTRL:        return recovery_csr_pkg::CSR_RECOVERY_CTRL;
      recovery_cmd_pkg::CMD_INDIRECT_FIFO_CTRL:   return recovery_csr_pkg::CSR_FIFO_CTRL_0;
      recovery_cmd_pkg::CMD_INDIRECT_FIFO_STATUS: return recovery_csr_pkg::CSR_FIFO_STATUS_0;
      default:                                    return recovery_csr_pkg::CSR_INVALID;
    endcase
  endfunction

  // Command validation
  assign in_range = (cmd_cmd_i >= recovery_cmd_pkg::CMD_RANGE_FIRST) &&
                    (cmd_cmd_i <= recovery_cmd_pkg::CMD_RANGE_LAST);
  assign mode_ok  = recovery_mode_enabled_i || (cmd_cmd_i <= recovery_cmd_pkg::CMD_BASE_LAST);
  // PROT_CAP, DEVICE_ID, HW_STATUS and vendor codes are not served
  assign dropped  = cmd_cmd_i inside {8'h22, 8'h23, [8'h28:8'h2A], 8'h2C};
  assign cmd_ok   = in_range && mode_ok && !dropped && !cmd_error_i &&
                    (cmd_is_rd_i || (cmd_len_i != '0));

  // Payload length in words, rounded up
  assign words = {2'b00, cmd_len_i[`RECOVERY_LEN_W-1:2]} + `RECOVERY_LEN_W'(|cmd_len_i[1:0]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (!cmd_ok) state_d = Error;
          else if (cmd_is_rd_i) state_d = CsrRead;
          else if (cmd_cmd_i == recovery_cmd_pkg::CMD_INDIRECT_FIFO_DATA) state_d = FifoWrite;
          else state_d = CsrWrite;
        end
      end
      CsrWrite, FifoWrite: begin
        if (tti_rx_rack_i && (cnt_q == `RECOVERY_LEN_W'(1))) state_d = Done;
      end
      CsrRead: begin
        if (res_ready_i) state_d = CsrReadLen;
      end
      CsrReadLen: state_d = CsrReadData;
      CsrReadData: begin
        if (host_abort_i) state_d = Error;
        else if (res_dready_i && (cnt_q == `RECOVERY_LEN_W'(1))) state_d = Done;
      end
      Error: state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      cnt_q       <= '0;
      bcnt_q      <= '0;
      cmd_q       <= '0;
      crc_q       <= 1'b0;
      len_q       <= '0;
      sel_q       <= recovery_csr_pkg::CSR_INVALID;
      rreq_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rreq_q      <= 1'b0;
      res_valid_q <= (state_q == CsrReadLen);
      case (state_q)
        Idle: begin
          if (cmd_valid_i) begin
            cnt_q  <= words;
            bcnt_q <= '0;
            cmd_q  <= cmd_cmd_i;
            crc_q  <= cmd_error_i;
            sel_q  <= first_word(cmd_cmd_i);
            rreq_q <= (state_d == CsrWrite) || (state_d == FifoWrite);
          end
        end
        CsrWrite, FifoWrite: begin
          if (tti_rx_rack_i) begin
            cnt_q  <= cnt_q - 1'b1;
            sel_q  <= recovery_csr_pkg::next_word(sel_q);
            rreq_q <= (cnt_q != `RECOVERY_LEN_W'(1));
          end
        end
        CsrReadLen: begin
          len_q <= recovery_cmd_pkg::read_len(cmd_q);
          cnt_q <= recovery_cmd_pkg::read_len(cmd_q);
        end
        CsrReadData: begin
          if (res_dready_i) begin
            cnt_q  <= cnt_q - 1'b1;
            bcnt_q <= bcnt_q + 1'b1;
            if (bcnt_q == 2'd3) sel_q <= recovery_csr_pkg::next_word(sel_q);
          end
        end
        default: ;
      endcase
    end
  end

  assign cmd_done_o     = (state_q == Done);
  assign rx_queue_clr_o = (state_q == Error);
  assign tti_rx_rreq_o  = rreq_q;

  // Read response, least significant byte of each word first
  assign res_valid_o  = res_valid_q;
  assign res_len_o    = len_q;
  assign res_dvalid_o = (state_q == CsrReadData);
  assign res_dlast_o  = res_dvalid_o && (cnt_q == `RECOVERY_LEN_W'(1));
  assign res_data_o   = csr.rd_data[{bcnt_q, 3'b000} +: 8];

  assign csr.sel       = sel_q;
  assign csr.wr_en     = (state_q == CsrWrite) && tti_rx_rack_i;
  assign csr.wr_data   = tti_rx_rdata_i;
  assign csr.status_we = (state_q == Done);
  assign csr.crc_err   = crc_q;

  assign fifo.push         = (state_q == FifoWrite) && tti_rx_rack_i;
  assign fifo.push_data    = tti_rx_rdata_i;
  assign fifo.stream_start = (state_q == Idle) && (state_d == FifoWrite);

  // The TTI responder only answers requests issued from the write states
  a_rack_in_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tti_rx_rack_i |-> state_q inside {CsrWrite, FifoWrite});

endmodule

`default_nettype wire

/* hdl/recovery_cmd_pkg.sv */
// Recovery command codes, protocol error codes and the read length table of the executor
`default_nettype none
`include "recovery_settings.svh"

package recovery_cmd_pkg;

  typedef logic [`RECOVERY_LEN_W-1:0] cmd_len_t;

  // Supported codes plus the bounds of the command range
  typedef enum logic [7:0] {
    CMD_RANGE_FIRST          = 8'h22,
    CMD_DEVICE_STATUS        = 8'h24,
    CMD_DEVICE_RESET         = 8'h25,
    CMD_RECOVERY_CTRL        = 8'h26,
    CMD_BASE_LAST            = 8'h27,
    CMD_INDIRECT_CTRL        = 8'h2B,
    CMD_INDIRECT_FIFO_CTRL   = 8'h2D,
    CMD_INDIRECT_FIFO_STATUS = 8'h2E,
    CMD_INDIRECT_FIFO_DATA   = 8'h2F
  } command_e;

  localparam command_e CMD_RANGE_LAST = CMD_INDIRECT_FIFO_DATA;

  typedef enum logic [7:0] {
    PROT_OK        = 8'h0,
    PROT_READ_ONLY = 8'h1,
    PROT_PARAMETER = 8'h2,
    PROT_LENGTH    = 8'h3,
    PROT_CRC       = 8'h4
  } protocol_error_e;

  // Response length in bytes of a read command
  function automatic cmd_len_t read_len(logic [7:0] cmd);
    case (cmd)
      CMD_DEVICE_STATUS:        return cmd_len_t'(8);
      CMD_DEVICE_RESET:         return cmd_len_t'(3);
      CMD_RECOVERY_CTRL:        return cmd_len_t'(3);
      CMD_INDIRECT_FIFO_CTRL:   return cmd_len_t'(6);
      CMD_INDIRECT_FIFO_STATUS: return cmd_len_t'(20);
      default:                  return cmd_len_t'(4);
    endcase
  endfunction

endpackage

`default_nettype wire

/* hdl/recovery_csr_file.sv */
// Recovery registers with the read word mux, protocol status, FIFO clear and image activation
`timescale 1ns/100ps
`default_nettype none
`include "recovery_settings.svh"

module recovery_csr_file (
  input  logic           clk_i,
  input  logic           rst_ni,
  csr_access_if.register csr,
  fifo_link_if.status    fifo,
  output logic           image_activated_o
);

  logic [23:0] device_reset_q;
  logic [23:0] recovery_ctrl_q;
  logic [31:0] fifo_ctrl0_q;
  logic [15:0] fifo_ctrl1_q;
  logic [7:0]  prot_status_q;
  logic        wr_ok;

  assign wr_ok = csr.wr_en && recovery_csr_pkg::is_writable(csr.sel);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
      fifo_ctrl0_q    <= '0;
      fifo_ctrl1_q    <= '0;
      prot_status_q   <= '0;
    end else begin
      if (wr_ok) begin
        case (csr.sel)
          recovery_csr_pkg::CSR_DEVICE_RESET:  device_reset_q  <= csr.wr_data[23:0];
          recovery_csr_pkg::CSR_RECOVERY_CTRL: recovery_ctrl_q <= csr.wr_data[23:0];
          recovery_csr_pkg::CSR_FIFO_CTRL_0:   fifo_ctrl0_q    <= csr.wr_data;
          // Image size LSB only
          recovery_csr_pkg::CSR_FIFO_CTRL_1:   fifo_ctrl1_q    <= csr.wr_data[15:0];
          default: ;
        endcase
      end
      // Protocol status is updated at the end of every command
      if (csr.status_we) begin
        prot_status_q <= csr.crc_err ? recovery_cmd_pkg::PROT_CRC : recovery_cmd_pkg::PROT_OK;
      end
    end
  end

  always_comb begin
    case (csr.sel)
      recovery_csr_pkg::CSR_DEVICE_STATUS_0: csr.rd_data = {16'h0, prot_status_q, 8'h0};
      recovery_csr_pkg::CSR_DEVICE_RESET:    csr.rd_data = {8'h0, device_reset_q};
      recovery_csr_pkg::CSR_RECOVERY_CTRL:   csr.rd_data = {8'h0, recovery_ctrl_q};
      recovery_csr_pkg::CSR_FIFO_CTRL_0:     csr.rd_data = fifo_ctrl0_q;
      recovery_csr_pkg::CSR_FIFO_CTRL_1:     csr.rd_data = {16'h0, fifo_ctrl1_q};
      recovery_csr_pkg::CSR_FIFO_STATUS_0:   csr.rd_data = {30'h0, fifo.full, fifo.empty};
      recovery_csr_pkg::CSR_FIFO_STATUS_1:   csr.rd_data = `RECOVERY_DATA_W'(fifo.wr_idx);
      recovery_csr_pkg::CSR_FIFO_STATUS_2:   csr.rd_data = `RECOVERY_DATA_W'(fifo.rd_idx);
      recovery_csr_pkg::CSR_FIFO_STATUS_3:   csr.rd_data = `RECOVERY_DATA_W'(`RECOVERY_FIFO_DEPTH);
      default:                               csr.rd_data = '0;
    endcase
  end

  // FIFO held empty while the reset byte reads 1
  assign fifo.clr = (fifo_ctrl0_q[15:8] == 8'd1);

  assign image_activated_o = (recovery_ctrl_q[23:16] == `RECOVERY_ACTIVATE_CODE);

  // Sequencer word selection must saturate at INVALID
  a_sel_in_map: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr.wr_en |-> csr.sel inside {[recovery_csr_pkg::CSR_DEVICE_STATUS_0 :
                                   recovery_csr_pkg::CSR_FIFO_STATUS_4],
                                  recovery_csr_pkg::CSR_INVALID});

endmodule

`default_nettype wire

/* hdl/recovery_csr_pkg.sv */
// Register word selector of the recovery CSRs and its writable-word classification
`default_nettype none

package recovery_csr_pkg;

  // Words of one command are consecutive codes
  typedef enum logic [7:0] {
    CSR_DEVICE_STATUS_0 = 8'd0,
    CSR_DEVICE_STATUS_1 = 8'd1,
    CSR_DEVICE_RESET    = 8'd2,
    CSR_RECOVERY_CTRL   = 8'd3,
    CSR_FIFO_CTRL_0     = 8'd4,
    CSR_FIFO_CTRL_1     = 8'd5,
    CSR_FIFO_STATUS_0   = 8'd6,
    CSR_FIFO_STATUS_1   = 8'd7,
    CSR_FIFO_STATUS_2   = 8'd8,
    CSR_FIFO_STATUS_3   = 8'd9,
    CSR_FIFO_STATUS_4   = 8'd10,
    CSR_INVALID         = 8'hFF
  } csr_word_e;

  function automatic logic is_writable(csr_word_e w);
    return w inside {CSR_DEVICE_RESET, CSR_RECOVERY_CTRL, CSR_FIFO_CTRL_0, CSR_FIFO_CTRL_1};
  endfunction

  // Saturates at INVALID so long payloads never wrap back into the map
  function automatic csr_word_e next_word(csr_word_e w);
    if (w >= CSR_FIFO_STATUS_4) return CSR_INVALID;
    return csr_word_e'(w + 8'd1);
  endfunction

endpackage

`default_nettype wire

/* hdl/recovery_ifs.sv */
// Internal links of the recovery executor: sequencer to registers, and the indirect FIFO link
`timescale 1ns/100ps
`default_nettype none
`include "recovery_settings.svh"

interface csr_access_if;
  recovery_csr_pkg::csr_word_e sel;
  logic                        wr_en;
  logic [`RECOVERY_DATA_W-1:0] wr_data;
  logic [`RECOVERY_DATA_W-1:0] rd_data;
  logic                        status_we;
  logic                        crc_err;

  modport sequencer(output sel, wr_en, wr_data, status_we, crc_err, input rd_data);
  modport register(input sel, wr_en, wr_data, status_we, crc_err, output rd_data);
endinterface

interface fifo_link_if;
  logic                        push;
  logic [`RECOVERY_DATA_W-1:0] push_data;
  logic                        stream_start;
  logic                        clr;
  logic                        full;
  logic                        empty;
  logic [`RECOVERY_IDX_W-1:0]  wr_idx;
  logic [`RECOVERY_IDX_W-1:0]  rd_idx;

  modport writer(output push, push_data, stream_start);
  modport store(
    input push, push_data, stream_start, clr,
    output full, empty, wr_idx, rd_idx
  );
  modport status(input full, empty, wr_idx, rd_idx, output clr);
endinterface

`default_nettype wire

/* hdl/recovery_indirect_fifo.sv */
// Indirect image FIFO fed by INDIRECT_FIFO_DATA writes and drained by the recovery consumer
`timescale 1ns/100ps
`default_nettype none
`include "recovery_settings.svh"

module recovery_indirect_fifo (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fifo_rd_req_i,
  fifo_link_if.store                  fifo,
  output logic [`RECOVERY_DATA_W-1:0] fifo_rd_data_o,
  output logic                        payload_available_o
);

  logic [`RECOVERY_DATA_W-1:0] mem_q [`RECOVERY_FIFO_DEPTH];
  logic [`RECOVERY_IDX_W-1:0]  wr_idx_q, rd_idx_q;
  logic [`RECOVERY_IDX_W:0]    count_q;
  logic                        push_ok, pop_ok;
  logic                        payload_q;

  function automatic logic [`RECOVERY_IDX_W-1:0] next_idx(logic [`RECOVERY_IDX_W-1:0] idx);
    if (idx == `RECOVERY_IDX_W'(`RECOVERY_FIFO_DEPTH - 1)) return '0;
    return idx + 1'b1;
  endfunction

  assign fifo.full  = (count_q == (`RECOVERY_IDX_W+1)'(`RECOVERY_FIFO_DEPTH));
  assign fifo.empty = (count_q == '0);
  assign push_ok    = fifo.push && !fifo.full;
  assign pop_ok     = fifo_rd_req_i && !fifo.empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      count_q  <= '0;
    end else if (fifo.clr) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_idx_q <= next_idx(wr_idx_q);
      if (pop_ok) rd_idx_q <= next_idx(rd_idx_q);
      if (push_ok && !pop_ok) count_q <= count_q + 1'b1;
      else if (pop_ok && !push_ok) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_idx_q] <= fifo.push_data;
  end

  // A read request clears the flag even when a new stream starts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) payload_q <= 1'b0;
    else if (fifo_rd_req_i) payload_q <= 1'b0;
    else if (fifo.stream_start) payload_q <= 1'b1;
  end

  assign fifo.wr_idx         = wr_idx_q;
  assign fifo.rd_idx         = rd_idx_q;
  assign fifo_rd_data_o      = mem_q[rd_idx_q];
  assign payload_available_o = payload_q;

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= (`RECOVERY_IDX_W+1)'(`RECOVERY_FIFO_DEPTH));

endmodule

`default_nettype wire

/* hdl/recovery_settings.svh */
// Project-wide widths, indirect FIFO depth and image activation code, included by the RTL
`ifndef RECOVERY_SETTINGS_SVH
`define RECOVERY_SETTINGS_SVH

// TTI, CSR and FIFO words share one width
`define RECOVERY_DATA_W 32
`define RECOVERY_LEN_W 16

// Indirect FIFO size in words, also reported in FIFO_STATUS_3
`define RECOVERY_FIFO_DEPTH 64
`define RECOVERY_IDX_W 6

// RECOVERY_CTRL byte 2 value that activates the recovery image
`define RECOVERY_ACTIVATE_CODE 8'h0F

`endif

/* hdl/recovery_top.sv */
// Recovery command executor top level joining sequencer, registers and indirect FIFO
`timescale 1ns/100ps
`default_nettype none
`include "recovery_settings.svh"

module recovery_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cmd_valid_i,
  input  logic                        cmd_is_rd_i,
  input  logic [7:0]                  cmd_cmd_i,
  input  logic [`RECOVERY_LEN_W-1:0]  cmd_len_i,
  input  logic                        cmd_error_i,
  output logic                        cmd_done_o,
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output logic [`RECOVERY_LEN_W-1:0]  res_len_o,
  output logic                        res_dvalid_o,
  input  logic                        res_dready_i,
  output logic [7:0]                  res_data_o,
  output logic                        res_dlast_o,
  output logic                        tti_rx_rreq_o,
  input  logic                        tti_rx_rack_i,
  input  logic [`RECOVERY_DATA_W-1:0] tti_rx_rdata_i,
  output logic                        rx_queue_clr_o,
  input  logic                        host_abort_i,
  input  logic                        recovery_mode_enabled_i,
  input  logic                        fifo_rd_req_i,
  output logic [`RECOVERY_DATA_W-1:0] fifo_rd_data_o,
  output logic                        payload_available_o,
  output logic                        image_activated_o
);

  csr_access_if csr_bus();
  fifo_link_if  fifo_bus();

  recovery_cmd_fsm i_cmd_fsm (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .cmd_valid_i             (cmd_valid_i),
    .cmd_is_rd_i             (cmd_is_rd_i),
    .cmd_cmd_i               (cmd_cmd_i),
    .cmd_len_i               (cmd_len_i),
    .cmd_error_i             (cmd_error_i),
    .cmd_done_o              (cmd_done_o),
    .res_valid_o             (res_valid_o),
    .res_ready_i             (res_ready_i),
    .res_len_o               (res_len_o),
    .res_dvalid_o            (res_dvalid_o),
    .res_dready_i            (res_dready_i),
    .res_data_o              (res_data_o),
    .res_dlast_o             (res_dlast_o),
    .tti_rx_rreq_o           (tti_rx_rreq_o),
    .tti_rx_rack_i           (tti_rx_rack_i),
    .tti_rx_rdata_i          (tti_rx_rdata_i),
    .rx_queue_clr_o          (rx_queue_clr_o),
    .host_abort_i            (host_abort_i),
    .recovery_mode_enabled_i (recovery_mode_enabled_i),
    .csr                     (csr_bus.sequencer),
    .fifo                    (fifo_bus.writer)
  );

  recovery_csr_file i_csr_file (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr               (csr_bus.register),
    .fifo              (fifo_bus.status),
    .image_activated_o (image_activated_o)
  );

  recovery_indirect_fifo i_indirect_fifo (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fifo_rd_req_i       (fifo_rd_req_i),
    .fifo                (fifo_bus.store),
    .fifo_rd_data_o      (fifo_rd_data_o),
    .payload_available_o (payload_available_o)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the recovery executor simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module recovery_tb -Mdir obj_dir -o recovery_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/recovery_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

/* verification/recovery_tb.sv */
// Random-stimulus testbench for recovery_top with TTI responder, register and FIFO models
`timescale 1ns/100ps
`default_nettype none

module recovery_tb;

  // Upper bounds on commands issued and cycles spent by the longest one
  // The 64-word image write takes up to four cycles a word
  localparam int NUM_CMDS       = 360;
  localparam int MAX_CMD_CYCLES = 320;
  localparam int CYCLE_LIMIT    = NUM_CMDS * MAX_CMD_CYCLES;

  logic        clk_i;
  logic        rst_ni;
  logic        cmd_valid_i;
  logic        cmd_is_rd_i;
  logic [7:0]  cmd_cmd_i;
  logic [15:0] cmd_len_i;
  logic        cmd_error_i;
  logic        res_ready_i;
  logic        res_dready_i;
  logic        tti_rx_rack_i;
  logic [31:0] tti_rx_rdata_i;
  logic        host_abort_i;
  logic        recovery_mode_enabled_i;
  logic        fifo_rd_req_i;
  logic        cmd_done_o;
  logic        res_valid_o;
  logic [15:0] res_len_o;
  logic        res_dvalid_o;
  logic [7:0]  res_data_o;
  logic        res_dlast_o;
  logic        tti_rx_rreq_o;
  logic        rx_queue_clr_o;
  logic [31:0] fifo_rd_data_o;
  logic        payload_available_o;
  logic        image_activated_o;

  integer      seed = 32'h939d6df4;
  int          cycles;
  int          errors;
  int          checks;
  int          test_errors;
  int          test_checks;
  int          rack_wait;
  int          last_at;
  int          exp_len;
  int          valid_seen;
  logic        saw_clr;
  logic [31:0] tti_q[$];
  logic [7:0]  got_q[$];
  logic [7:0]  exp_q[$];

  // Register and FIFO model state
  logic [23:0] m_dev_reset;
  logic [23:0] m_rec_ctrl;
  logic [31:0] m_fctrl0;
  logic [15:0] m_fctrl1;
  logic [7:0]  m_prot;
  logic [31:0] m_fifo[$];
  int          m_wr_idx;
  int          m_rd_idx;
  logic        m_payload;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) i_clock_gen (.clk_o(clk_i), .rst_no(rst_ni));

  recovery_top i_dut (.*);

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, a command never completed", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic int unsigned rnd(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    test_checks++;
    assert (cond) else begin
      $display("ERROR at %0t: %s", $time, what);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
    errors += test_errors;
    checks += test_checks;
    test_errors = 0;
    test_checks = 0;
  endtask

  // One cycle step; the TTI responder answers each request after 0 to 3 cycles
  task automatic tick();
    @(negedge clk_i);
    tti_rx_rack_i = 1'b0;
    if (tti_rx_rreq_o) rack_wait = int'(rnd(4));
    if (rack_wait == 0) begin
      tti_rx_rack_i = 1'b1;
      if (tti_q.size() > 0) tti_rx_rdata_i = tti_q.pop_front();
      else tti_rx_rdata_i = 32'hDEADBEEF;
      rack_wait = -1;
    end else if (rack_wait > 0) begin
      rack_wait--;
    end
  endtask

  function automatic logic cmd_accepted(input logic [7:0] code, input logic rd, input int len,
                                        input logic err);
    if (code < 8'h22 || code > 8'h2F) return 1'b0;
    if (code inside {8'h22, 8'h23, 8'h28, 8'h29, 8'h2A, 8'h2C}) return 1'b0;
    if (code > 8'h27 && !recovery_mode_enabled_i) return 1'b0;
    if (err) return 1'b0;
    if (!rd && len == 0) return 1'b0;
    return 1'b1;
  endfunction

  task automatic push_model(input logic [31:0] w);
    if (m_fctrl0[15:8] != 8'd1 && m_fifo.size() < 64) begin
      m_fifo.push_back(w);
      m_wr_idx = (m_wr_idx + 1) % 64;
    end
  endtask

  task automatic run_cmd(input logic [7:0] code, input logic rd, input int len,
                         input logic err, input int abort_at);
    logic done;
    got_q.delete();
    last_at    = -1;
    valid_seen = 0;
    saw_clr    = 1'b0;
    done       = 1'b0;
    tick();
    cmd_valid_i = 1'b1;
    cmd_cmd_i   = code;
    cmd_is_rd_i = rd;
    cmd_len_i   = 16'(len);
    cmd_error_i = err;
    while (!done) begin
      tick();
      cmd_valid_i  = 1'b0;
      cmd_error_i  = 1'b0;
      host_abort_i = 1'b0;
      if (rx_queue_clr_o) saw_clr = 1'b1;
      if (res_valid_o) begin
        valid_seen++;
        check_eq("res_len_o", 32'(res_len_o), 32'(exp_len));
      end
      if (cmd_done_o) begin
        done = 1'b1;
      end else begin
        res_ready_i  = (rnd(2) == 1);
        res_dready_i = (rnd(4) != 0);
        if (res_dvalid_o && abort_at >= 0 && got_q.size() == abort_at) begin
          host_abort_i = 1'b1;
          res_dready_i = 1'b0;
        end else if (res_dvalid_o && res_dready_i) begin
          got_q.push_back(res_data_o);
          if (res_dlast_o) last_at = got_q.size();
        end
      end
    end
    res_ready_i  = 1'b0;
    res_dready_i = 1'b0;
  endtask

  task automatic verify_flags();
    check_eq("image_activated_o", 32'(image_activated_o), 32'(m_rec_ctrl[23:16] == 8'h0F));
    check_eq("payload_available_o", 32'(payload_available_o), 32'(m_payload));
  endtask

  task automatic write_cmd(input logic [7:0] code, input int len, input logic err,
                           input logic [31:0] w0, input logic use_w0);
    logic [31:0] w[$];
    logic [31:0] wd;
    logic        ok;
    int          s;
    ok = cmd_accepted(code, 1'b0, len, err);
    for (int i = 0; i < (len + 3) / 4; i++) begin
      wd = $random(seed);
      if (code == 8'h26 && rnd(2) == 0) wd[23:16] = 8'h0F;
      if (code == 8'h2D) wd[15:8] = (rnd(4) == 0) ? 8'd1 : 8'd0;
      if (i == 0 && use_w0) wd = w0;
      w.push_back(wd);
      tti_q.push_back(wd);
    end
    exp_len = 0;
    run_cmd(code, 1'b0, len, err, -1);
    check_true(saw_clr == !ok, "rx_queue_clr_o disagrees with command acceptance");
    check_eq("res_valid_o pulses", 32'(valid_seen), 32'd0);
    tti_q.delete();
    if (ok && code == 8'h2F) begin
      m_payload = 1'b1;
      foreach (w[i]) push_model(w[i]);
    end else if (ok) begin
      case (code)
        8'h24: s = 0;
        8'h25: s = 2;
        8'h26: s = 3;
        8'h2D: s = 4;
        8'h2E: s = 6;
        default: s = -1;
      endcase
      foreach (w[i]) begin
        case (s)
          2: m_dev_reset = w[i][23:0];
          3: m_rec_ctrl  = w[i][23:0];
          4: m_fctrl0    = w[i];
          5: m_fctrl1    = w[i][15:0];
          default: ;
        endcase
        s = (s < 0 || s >= 10) ? -1 : s + 1;
      end
    end
    if (m_fctrl0[15:8] == 8'd1) begin
      m_fifo.delete();
      m_wr_idx = 0;
      m_rd_idx = 0;
    end
    m_prot = err ? 8'd4 : 8'd0;
    verify_flags();
  endtask

  task automatic read_cmd(input logic [7:0] code, input int abort_at);
    logic [31:0] wd[5];
    foreach (wd[i]) wd[i] = 32'h0;
    case (code)
      8'h24: begin
        wd[0] = {16'h0, m_prot, 8'h0};
        exp_len = 8;
      end
      8'h25: begin
        wd[0] = {8'h0, m_dev_reset};
        exp_len = 3;
      end
      8'h26: begin
        wd[0] = {8'h0, m_rec_ctrl};
        exp_len = 3;
      end
      8'h2D: begin
        wd[0] = m_fctrl0;
        wd[1] = {16'h0, m_fctrl1};
        exp_len = 6;
      end
      default: begin
        wd[0] = {30'h0, m_fifo.size() == 64, m_fifo.size() == 0};
        wd[1] = 32'(m_wr_idx);
        wd[2] = 32'(m_rd_idx);
        wd[3] = 32'd64;
        exp_len = 20;
      end
    endcase
    exp_q.delete();
    for (int i = 0; i < exp_len; i++) exp_q.push_back(wd[i / 4][8 * (i % 4) +: 8]);
    run_cmd(code, 1'b1, 0, 1'b0, abort_at);
    check_eq("res_valid_o pulses", 32'(valid_seen), 32'd1);
    if (abort_at < 0) begin
      check_eq("res byte count", 32'(got_q.size()), 32'(exp_len));
      check_eq("res_dlast_o position", 32'(last_at), 32'(exp_len));
      check_true(!saw_clr, "rx_queue_clr_o raised during a clean read");
    end else begin
      check_eq("res byte count", 32'(got_q.size()), 32'(abort_at));
      check_true(saw_clr, "abort did not raise rx_queue_clr_o");
      check_true(last_at < 0, "res_dlast_o seen on an aborted read");
    end
    foreach (got_q[i]) if (i < exp_len) check_eq("res_data_o", 32'(got_q[i]), 32'(exp_q[i]));
    m_prot = 8'd0;
    verify_flags();
  endtask

  task automatic pop_fifo(input int n);
    repeat (n) begin
      tick();
      if (m_fifo.size() > 0) check_eq("fifo_rd_data_o", fifo_rd_data_o, m_fifo[0]);
      fifo_rd_req_i = 1'b1;
      tick();
      fifo_rd_req_i = 1'b0;
      if (m_fifo.size() > 0) begin
        void'(m_fifo.pop_front());
        m_rd_idx = (m_rd_idx + 1) % 64;
      end
      m_payload = 1'b0;
      check_eq("payload_available_o", 32'(payload_available_o), 32'(0));
    end
  endtask

  initial begin
    logic [7:0] code;
    int         kind;
    cmd_valid_i             = 1'b0;
    cmd_is_rd_i             = 1'b0;
    cmd_cmd_i               = 8'h0;
    cmd_len_i               = 16'h0;
    cmd_error_i             = 1'b0;
    res_ready_i             = 1'b0;
    res_dready_i            = 1'b0;
    tti_rx_rack_i           = 1'b0;
    tti_rx_rdata_i          = 32'h0;
    host_abort_i            = 1'b0;
    recovery_mode_enabled_i = 1'b1;
    fifo_rd_req_i           = 1'b0;
    cycles      = 0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    test_checks = 0;
    rack_wait   = -1;
    m_dev_reset = '0;
    m_rec_ctrl  = '0;
    m_fctrl0    = '0;
    m_fctrl1    = '0;
    m_prot      = '0;
    m_wr_idx    = 0;
    m_rd_idx    = 0;
    m_payload   = 1'b0;
    @(posedge rst_ni);
    verify_flags();

    repeat (30) begin
      kind = int'(rnd(3));
      code = (kind == 0) ? 8'h25 : (kind == 1) ? 8'h26 : 8'h2D;
      write_cmd(code, 1 + int'(rnd(8)), 1'b0, 32'h0, 1'b0);
      read_cmd(code, -1);
    end
    finish_test("csr_write_read");

    repeat (24) begin
      kind = int'(rnd(4));
      case (kind)
        0: code = (rnd(2) == 0) ? 8'(rnd(8'h22)) : 8'(8'h30 + rnd(8'hD0));
        1: begin
          if (rnd(2) == 0) code = 8'(8'h22 + rnd(2));
          else if (rnd(4) == 0) code = 8'h2C;
          else code = 8'(8'h28 + rnd(3));
        end
        2: code = 8'(8'h28 + rnd(8));
        default: code = 8'(8'h25 + rnd(2));
      endcase
      if (kind == 2) recovery_mode_enabled_i = 1'b0;
      write_cmd(code, (kind == 3) ? 0 : 1 + int'(rnd(8)), 1'b0, 32'h0, 1'b0);
      recovery_mode_enabled_i = 1'b1;
      read_cmd(8'h25, -1);
      read_cmd(8'h26, -1);
      read_cmd(8'h2D, -1);
    end
    finish_test("command_rejection");

    repeat (8) begin
      write_cmd(8'h25, 1 + int'(rnd(4)), 1'b1, 32'h0, 1'b0);
      read_cmd(8'h24, -1);
      read_cmd(8'h24, -1);
    end
    finish_test("protocol_status");

    write_cmd(8'h2D, 4, 1'b0, 32'h0, 1'b1);
    repeat (6) begin
      write_cmd(8'h2F, 1 + int'(rnd(64)), 1'b0, 32'h0, 1'b0);
      read_cmd(8'h2E, -1);
      pop_fifo(int'(rnd(6)));
    end
    write_cmd(8'h2F, 256, 1'b0, 32'h0, 1'b0);
    read_cmd(8'h2E, -1);
    pop_fifo(20);
    write_cmd(8'h2F, 1 + int'(rnd(64)), 1'b0, 32'h0, 1'b0);
    read_cmd(8'h2E, -1);
    pop_fifo(10);
    finish_test("image_streaming");

    write_cmd(8'h2D, 2, 1'b0, 32'h0000_0100, 1'b1);
    read_cmd(8'h2E, -1);
    write_cmd(8'h2D, 2, 1'b0, 32'h0, 1'b1);
    write_cmd(8'h26, 3, 1'b0, 32'h000F_0000, 1'b1);
    write_cmd(8'h26, 3, 1'b0, 32'h0003_0000, 1'b1);
    finish_test("clear_activation");

    repeat (6) begin
      read_cmd(8'h2E, int'(rnd(19)));
      read_cmd(8'h2D, int'(rnd(5)));
    end
    finish_test("abort");

    $display("Tests finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock and reset source for the recovery executor simulation
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  // Release reset away from the rising edge
  initial begin
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/recovery_cmd_pkg.sv
hdl/recovery_csr_pkg.sv
hdl/recovery_ifs.sv
hdl/recovery_cmd_fsm.sv
hdl/recovery_csr_file.sv
hdl/recovery_indirect_fifo.sv
hdl/recovery_top.sv
verification/tb_clock_gen.sv
verification/recovery_tb.sv
